// File: rtl/board_pkg.sv
// Shared widths, APB register map and cage state; offsets are byte addresses, word aligned
package board_pkg;

    // Board I/O widths
    localparam int SW_W   = 8;
    localparam int GPIO_W = SW_W + 1;
    localparam int LED_W  = 8;

    // APB bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Switches in [7:0], button in [8], read only
    localparam logic [APB_ADDR_W-1:0] REG_SWITCH       = 8'h00;
    // LED drive, low eight bits
    localparam logic [APB_ADDR_W-1:0] REG_LED          = 8'h04;
    // One bit per cage, set while a module is seated
    localparam logic [APB_ADDR_W-1:0] REG_PORT_PRESENT = 8'h08;
    // Set while the cage is out of reset
    localparam logic [APB_ADDR_W-1:0] REG_PORT_READY   = 8'h0C;
    // Set while the module pulls intl low
    localparam logic [APB_ADDR_W-1:0] REG_PORT_INT     = 8'h10;
    // Per-port interrupt enable
    localparam logic [APB_ADDR_W-1:0] REG_INT_MASK     = 8'h14;
    // Write 1 to restart a ready port, reads as zero
    localparam logic [APB_ADDR_W-1:0] REG_PORT_RESET   = 8'h18;

    // Cage sequencing state
    typedef enum logic [1:0] {
        ABSENT = 2'd0,
        RESET  = 2'd1,
        READY  = 2'd2
    } port_state_t;

endpackage

// File: rtl/port_mgmt_if.sv
// Port status and reset requests between cage control and registers; sw_reset is a 1-cycle pulse
interface port_mgmt_if #(
    parameter int PORT_CNT = 15
);

    logic [PORT_CNT-1:0] present;
    logic [PORT_CNT-1:0] ready;
    logic [PORT_CNT-1:0] int_active;
    logic [PORT_CNT-1:0] sw_reset;

    modport ctrl (
        output present,
        output ready,
        output int_active,
        input  sw_reset
    );

    modport regs (
        input  present,
        input  ready,
        input  int_active,
        output sw_reset
    );

endinterface

// File: rtl/tick_timer.sv
// One-shot down counter; load_i must be at least 1, start_i restarts it even while busy
module tick_timer #(
    parameter int CNT_W = 17
) (
    input  wire logic             clk_125mhz,
    input  wire logic             arst_n_i,
    input  wire logic             start_i,
    input  wire logic [CNT_W-1:0] load_i,
    output wire logic             busy_o,
    output wire logic             done_o
);

    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    logic             done_q;

    // done_q rises load_i cycles after the start cycle
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (start_i) begin
            cnt_q  <= load_i - 1'b1;
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else begin
            done_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// File: rtl/debounce_switch.sv
// Debounces asynchronous inputs; N and RATE must be 2 or more, RATE is the sample period in cycles
module debounce_switch import board_pkg::*; #(
    parameter int RATE = 125000,
    parameter int N    = 4
) (
    input  wire logic              clk_125mhz,
    input  wire logic              arst_n_i,
    input  wire logic [GPIO_W-1:0] in_i,
    output wire logic [GPIO_W-1:0] out_o
);

    localparam int               CNT_W   = $clog2(RATE + 1);
    // Reload costs one cycle, so the count is one short of the period
    localparam logic [CNT_W-1:0] RATE_LD = CNT_W'(RATE - 1);

    logic [GPIO_W-1:0]         sync1_q;
    logic [GPIO_W-1:0]         sync2_q;
    logic [GPIO_W-1:0][N-1:0]  hist_q;
    logic [GPIO_W-1:0]         out_q;
    logic                      tmr_busy;
    logic                      tick;

    // Free running: reload whenever the count has expired
    tick_timer #(
        .CNT_W(CNT_W)
    ) rate_timer (
        .clk_125mhz(clk_125mhz),
        .arst_n_i  (arst_n_i),
        .start_i   (!tmr_busy),
        .load_i    (RATE_LD),
        .busy_o    (tmr_busy),
        .done_o    (tick)
    );

    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= in_i;
            sync2_q <= sync1_q;
        end
    end

    // Sample history, newest sample in bit 0
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q <= '0;
        end else if (tick) begin
            for (int i = 0; i < GPIO_W; i++) begin
                hist_q[i] <= {hist_q[i][N-2:0], sync2_q[i]};
            end
        end
    end

    // Output moves only on a unanimous history
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_W; i++) begin
                if (&hist_q[i]) begin
                    out_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    out_q[i] <= 1'b0;
                end
            end
        end
    end

    assign out_o = out_q;

endmodule

// File: rtl/qsfp_port_ctrl.sv
// Per-cage QSFP reset sequencing; RESET_HOLD must be 2 or more, pins are active low and async
module qsfp_port_ctrl import board_pkg::*; #(
    parameter int PORT_CNT   = 15,
    parameter int RESET_HOLD = 1000
) (
    input  wire logic                clk_125mhz,
    input  wire logic                arst_n_i,
    input  wire logic [PORT_CNT-1:0] modprsl_i,
    input  wire logic [PORT_CNT-1:0] intl_i,
    output wire logic [PORT_CNT-1:0] resetl_o,
    port_mgmt_if.ctrl                mgmt
);

    localparam int               HOLD_W  = $clog2(RESET_HOLD + 1);
    // Timer fires one cycle early, the state update adds the last cycle
    localparam logic [HOLD_W-1:0] HOLD_LD = HOLD_W'(RESET_HOLD - 1);

    logic [PORT_CNT-1:0] modprsl_s1_q;
    logic [PORT_CNT-1:0] modprsl_s2_q;
    logic [PORT_CNT-1:0] intl_s1_q;
    logic [PORT_CNT-1:0] intl_s2_q;
    logic [PORT_CNT-1:0] present;
    logic [PORT_CNT-1:0] tmr_start;
    logic [PORT_CNT-1:0] tmr_done;
    logic [PORT_CNT-1:0] resetl_q;
    port_state_t         state_q [PORT_CNT];
    port_state_t         state_d [PORT_CNT];

    // Idle level of both pins is high
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            modprsl_s1_q <= '1;
            modprsl_s2_q <= '1;
            intl_s1_q    <= '1;
            intl_s2_q    <= '1;
        end else begin
            modprsl_s1_q <= modprsl_i;
            modprsl_s2_q <= modprsl_s1_q;
            intl_s1_q    <= intl_i;
            intl_s2_q    <= intl_s1_q;
        end
    end

    assign present = ~modprsl_s2_q;

    for (genvar i = 0; i < PORT_CNT; i++) begin : g_port
        tick_timer #(
            .CNT_W(HOLD_W)
        ) hold_timer (
            .clk_125mhz(clk_125mhz),
            .arst_n_i  (arst_n_i),
            .start_i   (tmr_start[i]),
            .load_i    (HOLD_LD),
            .busy_o    (),
            .done_o    (tmr_done[i])
        );
    end

    always_comb begin
        for (int i = 0; i < PORT_CNT; i++) begin
            state_d[i]   = state_q[i];
            tmr_start[i] = 1'b0;
            // Removal wins over everything else
            if (!present[i]) begin
                state_d[i] = ABSENT;
            end else begin
                case (state_q[i])
                    ABSENT: begin
                        state_d[i]   = RESET;
                        tmr_start[i] = 1'b1;
                    end
                    RESET: begin
                        if (tmr_done[i]) begin
                            state_d[i] = READY;
                        end
                    end
                    READY: begin
                        if (mgmt.sw_reset[i]) begin
                            state_d[i]   = RESET;
                            tmr_start[i] = 1'b1;
                        end
                    end
                    default: state_d[i] = ABSENT;
                endcase
            end
        end
    end

    // resetl registered from next state so it lines up with state_q
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PORT_CNT; i++) begin
                state_q[i] <= ABSENT;
            end
            resetl_q <= '0;
        end else begin
            for (int i = 0; i < PORT_CNT; i++) begin
                state_q[i]  <= state_d[i];
                resetl_q[i] <= (state_d[i] == READY);
            end
        end
    end

    assign resetl_o        = resetl_q;
    assign mgmt.present    = present;
    assign mgmt.ready      = resetl_q;
    assign mgmt.int_active = ~intl_s2_q;

endmodule

// File: rtl/apb_regs.sv
// Zero-wait APB slave, PREADY tied high; PORT_CNT up to APB_DATA_W, only exact offsets decode
module apb_regs import board_pkg::*; #(
    parameter int PORT_CNT = 15
) (
    input  wire logic                  clk_125mhz,
    input  wire logic                  arst_n_i,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [APB_ADDR_W-1:0] paddr_i,
    input  wire logic [APB_DATA_W-1:0] pwdata_i,
    output wire logic [APB_DATA_W-1:0] prdata_o,
    output wire logic                  pready_o,
    output wire logic                  pslverr_o,
    input  wire logic [GPIO_W-1:0]     gpio_i,
    output wire logic [LED_W-1:0]      led_o,
    output wire logic                  irq_o,
    port_mgmt_if.regs                  mgmt
);

    logic                  access;
    logic                  wr_ok;
    logic                  addr_hit;
    logic                  read_only;
    logic [APB_DATA_W-1:0] rd_data;
    logic [LED_W-1:0]      led_q;
    logic [PORT_CNT-1:0]   int_mask_q;
    logic [PORT_CNT-1:0]   sw_reset_q;
    logic                  irq_q;

    // Access phase of a transfer
    assign access = psel_i && penable_i;

    always_comb begin
        rd_data   = '0;
        addr_hit  = 1'b1;
        read_only = 1'b0;
        case (paddr_i)
            REG_SWITCH: begin
                rd_data   = APB_DATA_W'(gpio_i);
                read_only = 1'b1;
            end
            REG_LED: rd_data = APB_DATA_W'(led_q);
            REG_PORT_PRESENT: begin
                rd_data   = APB_DATA_W'(mgmt.present);
                read_only = 1'b1;
            end
            REG_PORT_READY: begin
                rd_data   = APB_DATA_W'(mgmt.ready);
                read_only = 1'b1;
            end
            REG_PORT_INT: begin
                rd_data   = APB_DATA_W'(mgmt.int_active);
                read_only = 1'b1;
            end
            REG_INT_MASK: rd_data = APB_DATA_W'(int_mask_q);
            // Write-only strobe register
            REG_PORT_RESET: rd_data = '0;
            default: addr_hit = 1'b0;
        endcase
    end

    assign wr_ok = access && pwrite_i && addr_hit && !read_only;

    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q      <= '0;
            int_mask_q <= '0;
        end else if (wr_ok) begin
            if (paddr_i == REG_LED) begin
                led_q <= pwdata_i[LED_W-1:0];
            end
            if (paddr_i == REG_INT_MASK) begin
                int_mask_q <= pwdata_i[PORT_CNT-1:0];
            end
        end
    end

    // Single-cycle pulse since each access phase lasts one cycle
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_reset_q <= '0;
        end else if (wr_ok && paddr_i == REG_PORT_RESET) begin
            sw_reset_q <= pwdata_i[PORT_CNT-1:0];
        end else begin
            sw_reset_q <= '0;
        end
    end

    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(mgmt.int_active & int_mask_q);
        end
    end

    assign prdata_o      = (access && !pwrite_i) ? rd_data : '0;
    assign pready_o      = 1'b1;
    assign pslverr_o     = access && (!addr_hit || (pwrite_i && read_only));
    assign led_o         = led_q;
    assign irq_o         = irq_q;
    assign mgmt.sw_reset = sw_reset_q;

endmodule

// File: rtl/board_mgmt.sv
// Board management top level; expects a free-running 125 MHz clock, all board inputs are async
module board_mgmt import board_pkg::*; #(
    parameter int PORT_CNT      = 15,
    parameter int DEBOUNCE_RATE = 125000,
    parameter int DEBOUNCE_N    = 4,
    parameter int RESET_HOLD    = 1000
) (
    input  wire logic                  clk_125mhz,
    input  wire logic                  arst_n_i,

    // GPIO
    input  wire logic                  btn_i,
    input  wire logic [SW_W-1:0]       sw_i,
    output wire logic [LED_W-1:0]      led_o,

    // APB slave
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [APB_ADDR_W-1:0] paddr_i,
    input  wire logic [APB_DATA_W-1:0] pwdata_i,
    output wire logic [APB_DATA_W-1:0] prdata_o,
    output wire logic                  pready_o,
    output wire logic                  pslverr_o,

    // QSFP cage sideband
    input  wire logic [PORT_CNT-1:0]   qsfp_modprsl_i,
    input  wire logic [PORT_CNT-1:0]   qsfp_intl_i,
    output wire logic [PORT_CNT-1:0]   qsfp_resetl_o,

    output wire logic                  irq_o
);

    logic [GPIO_W-1:0] gpio_db;

    port_mgmt_if #(.PORT_CNT(PORT_CNT)) mgmt_if ();

    // Button sits above the switches
    debounce_switch #(
        .RATE(DEBOUNCE_RATE),
        .N   (DEBOUNCE_N)
    ) u_debounce (
        .clk_125mhz(clk_125mhz),
        .arst_n_i  (arst_n_i),
        .in_i      ({btn_i, sw_i}),
        .out_o     (gpio_db)
    );

    qsfp_port_ctrl #(
        .PORT_CNT  (PORT_CNT),
        .RESET_HOLD(RESET_HOLD)
    ) u_port_ctrl (
        .clk_125mhz(clk_125mhz),
        .arst_n_i  (arst_n_i),
        .modprsl_i (qsfp_modprsl_i),
        .intl_i    (qsfp_intl_i),
        .resetl_o  (qsfp_resetl_o),
        .mgmt      (mgmt_if.ctrl)
    );

    apb_regs #(
        .PORT_CNT(PORT_CNT)
    ) u_regs (
        .clk_125mhz(clk_125mhz),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .gpio_i    (gpio_db),
        .led_o     (led_o),
        .irq_o     (irq_o),
        .mgmt      (mgmt_if.regs)
    );

endmodule

// File: testbench/board_mgmt_sva.sv
// Bound into board_mgmt and reads the port controller state directly; all checks idle in reset
module board_mgmt_sva import board_pkg::*; #(
    parameter int PORT_CNT = 15
) (
    input logic                clk_125mhz,
    input logic                arst_n_i,
    input logic                psel_i,
    input logic                pready_i,
    input logic [PORT_CNT-1:0] sw_reset_i,
    input logic [PORT_CNT-1:0] resetl_i,
    input port_state_t         state_i [PORT_CNT]
);

    timeunit 1ns;
    timeprecision 1ps;

    // Zero-wait slave
    apb_ready: assert property (@(posedge clk_125mhz) disable iff (!arst_n_i)
        psel_i |-> pready_i)
        else $error("pready low during a selected transfer");

    for (genvar i = 0; i < PORT_CNT; i++) begin : g_cage
        cage_ready: assert property (@(posedge clk_125mhz) disable iff (!arst_n_i)
            (state_i[i] == READY) |-> resetl_i[i])
            else $error("cage %0d is READY while resetl is low", i);

        // Request is a single-cycle strobe
        sw_pulse: assert property (@(posedge clk_125mhz) disable iff (!arst_n_i)
            sw_reset_i[i] |=> !sw_reset_i[i])
            else $error("sw_reset of cage %0d high for two cycles", i);
    end

endmodule

bind board_mgmt board_mgmt_sva #(
    .PORT_CNT(PORT_CNT)
) u_sva (
    .clk_125mhz(clk_125mhz),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .pready_i  (pready_o),
    .sw_reset_i(mgmt_if.sw_reset),
    .resetl_i  (qsfp_resetl_o),
    .state_i   (u_port_ctrl.state_q)
);

// File: testbench/tb_board_mgmt.sv
// Directed testbench with 4 cages, debounce rate 8 and reset hold 20; every wait is bounded
module tb_board_mgmt import board_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PORT_CNT   = 4;
    localparam int DB_RATE    = 8;
    localparam int DB_N       = 4;
    localparam int RESET_HOLD = 20;
    localparam int DB_HOLD    = (DB_N + 1) * DB_RATE + 3;
    localparam int APB_TMO    = 16;
    localparam int PORT_TMO   = RESET_HOLD + 40;
    // Cycles per APB transfer as driven here
    localparam int APB_CYC      = 3;
    localparam int GLITCH_READS = ((DB_N - 1) * DB_RATE - 1) / APB_CYC;

    logic                  clk;
    logic                  arst_n;
    logic                  btn;
    logic [SW_W-1:0]       sw;
    logic [LED_W-1:0]      led;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic [PORT_CNT-1:0]   modprsl;
    logic [PORT_CNT-1:0]   intl;
    logic [PORT_CNT-1:0]   resetl;
    logic                  irq;
    int                    err_cnt;

    board_mgmt #(
        .PORT_CNT     (PORT_CNT),
        .DEBOUNCE_RATE(DB_RATE),
        .DEBOUNCE_N   (DB_N),
        .RESET_HOLD   (RESET_HOLD)
    ) DUT (
        .clk_125mhz    (clk),
        .arst_n_i      (arst_n),
        .btn_i         (btn),
        .sw_i          (sw),
        .led_o         (led),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .qsfp_modprsl_i(modprsl),
        .qsfp_intl_i   (intl),
        .qsfp_resetl_o (resetl),
        .irq_o         (irq)
    );

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Setup then access phase, response sampled on the falling edge
    task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                                input logic [APB_DATA_W-1:0] wdata,
                                output logic [APB_DATA_W-1:0] rdata, output logic slverr);
        int n;
        n = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && n < APB_TMO) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("Timeout: pready never rose for the transfer at offset %0h", addr);
            err_cnt++;
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic slverr);
        logic [APB_DATA_W-1:0] unused;
        apb_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic slverr);
        apb_transfer(1'b0, addr, '0, data, slverr);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_resetl(input logic [PORT_CNT-1:0] bits, input logic level,
                               output int cycles);
        logic [PORT_CNT-1:0] target;
        target = level ? bits : '0;
        cycles = 0;
        @(negedge clk);
        while ((resetl & bits) != target && cycles < PORT_TMO) begin
            @(negedge clk);
            cycles++;
        end
        if ((resetl & bits) != target) begin
            $display("Timeout: resetl of ports %0h never reached level %0d", bits, level);
            err_cnt++;
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== level && n < APB_TMO) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            $display("Timeout: irq_o never went to level %0d", level);
            err_cnt++;
        end
    endtask

    task automatic reset_and_led();
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        logic [LED_W-1:0]      val;
        @(negedge clk);
        check("led_o", led, 0);
        check("qsfp_resetl_o", resetl, 0);
        check("irq_o", irq, 0);
        repeat (4) begin
            val = LED_W'($urandom_range(0, 255));
            apb_write(REG_LED, APB_DATA_W'(val), err);
            check("pslverr", err, 0);
            @(negedge clk);
            check("led_o", led, val);
            apb_read(REG_LED, rd, err);
            check("REG_LED", rd, val);
        end
    endtask

    task automatic switch_debounce();
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        logic [GPIO_W-1:0]     val;
        repeat (3) begin
            val = GPIO_W'($urandom_range(0, 511));
            @(posedge clk);
            btn <= val[GPIO_W-1];
            sw  <= val[SW_W-1:0];
            wait_cycles(DB_HOLD);
            apb_read(REG_SWITCH, rd, err);
            check("REG_SWITCH", rd, val);
        end
        // Inverted glitch, too short to pass, watched while it lasts and after
        @(posedge clk);
        btn <= ~val[GPIO_W-1];
        sw  <= ~val[SW_W-1:0];
        repeat (GLITCH_READS) begin
            apb_read(REG_SWITCH, rd, err);
            check("REG_SWITCH during glitch", rd, val);
        end
        btn <= val[GPIO_W-1];
        sw  <= val[SW_W-1:0];
        repeat (DB_HOLD / APB_CYC + 1) begin
            apb_read(REG_SWITCH, rd, err);
            check("REG_SWITCH after glitch", rd, val);
        end
    endtask

    task automatic insert_and_remove(output logic [PORT_CNT-1:0] ins);
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        logic [PORT_CNT-1:0]   gone;
        int                    cycles;
        ins = PORT_CNT'($urandom_range(1, (1 << (PORT_CNT - 1)) - 1));
        // Top cage always seated so a software reset has bystanders
        ins[PORT_CNT-1] = 1'b1;
        @(posedge clk);
        modprsl <= ~ins;
        wait_resetl(ins, 1'b1, cycles);
        check("qsfp_resetl_o early rise", cycles < RESET_HOLD, 0);
        check("qsfp_resetl_o", resetl, ins);
        apb_read(REG_PORT_PRESENT, rd, err);
        check("REG_PORT_PRESENT", rd, ins);
        apb_read(REG_PORT_READY, rd, err);
        check("REG_PORT_READY", rd, ins);
        // Pull the lowest seated module
        gone = ins & (~ins + 1'b1);
        @(posedge clk);
        modprsl <= ~(ins & ~gone);
        wait_resetl(gone, 1'b0, cycles);
        apb_read(REG_PORT_READY, rd, err);
        check("REG_PORT_READY", rd, ins & ~gone);
        apb_read(REG_PORT_PRESENT, rd, err);
        check("REG_PORT_PRESENT", rd, ins & ~gone);
        @(posedge clk);
        modprsl <= ~ins;
        wait_resetl(ins, 1'b1, cycles);
    endtask

    task automatic software_reset(input logic [PORT_CNT-1:0] ins);
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        logic [PORT_CNT-1:0]   target;
        logic [PORT_CNT-1:0]   others;
        logic                  others_ok;
        int                    cycles;
        int                    lows;
        target    = ins & (~ins + 1'b1);
        others    = ins & ~target;
        others_ok = 1'b1;
        lows      = 0;
        apb_write(REG_PORT_RESET, APB_DATA_W'(target), err);
        check("pslverr", err, 0);
        wait_resetl(target, 1'b0, cycles);
        while ((resetl & target) == '0 && lows < PORT_TMO) begin
            if ((resetl & others) != others) begin
                others_ok = 1'b0;
            end
            lows++;
            @(negedge clk);
        end
        check("qsfp_resetl_o low cycles", lows, RESET_HOLD);
        check("qsfp_resetl_o other ports", others_ok, 1);
        apb_read(REG_PORT_RESET, rd, err);
        check("REG_PORT_RESET", rd, 0);
    endtask

    task automatic interrupt_masking();
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        logic [PORT_CNT-1:0]   bitp;
        logic                  irq_seen;
        int                    n;
        bitp     = PORT_CNT'(1) << $urandom_range(0, PORT_CNT - 1);
        irq_seen = 1'b0;
        n        = 0;
        rd       = '0;
        @(posedge clk);
        intl <= ~bitp;
        while (rd != APB_DATA_W'(bitp) && n < 8) begin
            apb_read(REG_PORT_INT, rd, err);
            n++;
        end
        check("REG_PORT_INT", rd, bitp);
        repeat (6) begin
            @(negedge clk);
            irq_seen = irq_seen | irq;
        end
        check("irq_o while masked", irq_seen, 0);
        apb_write(REG_INT_MASK, APB_DATA_W'(bitp), err);
        apb_read(REG_INT_MASK, rd, err);
        check("REG_INT_MASK", rd, bitp);
        wait_irq(1'b1);
        @(posedge clk);
        intl <= '1;
        wait_irq(1'b0);
        apb_read(REG_PORT_INT, rd, err);
        check("REG_PORT_INT", rd, 0);
        apb_write(REG_INT_MASK, '0, err);
    endtask

    task automatic slave_errors(input logic [PORT_CNT-1:0] ins);
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        apb_read(8'h1C, rd, err);
        check("pslverr unmapped 0x1c", err, 1);
        apb_read(8'hFC, rd, err);
        check("pslverr unmapped 0xfc", err, 1);
        apb_write(REG_PORT_PRESENT, APB_DATA_W'(~ins), err);
        check("pslverr read-only write", err, 1);
        apb_read(REG_PORT_PRESENT, rd, err);
        check("pslverr", err, 0);
        check("REG_PORT_PRESENT", rd, ins);
    endtask

    initial begin
        logic [PORT_CNT-1:0] ins;
        void'($urandom(32'h03dedd08));
        err_cnt = 0;
        clk     = 1'b0;
        arst_n  = 1'b0;
        btn     = 1'b0;
        sw      = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        modprsl = '1;
        intl    = '1;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        reset_and_led();
        switch_debounce();
        insert_and_remove(ins);
        software_reset(ins);
        interrupt_masking();
        slave_errors(ins);
        $display("Checks finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/board_pkg.sv
rtl/port_mgmt_if.sv
rtl/tick_timer.sv
rtl/debounce_switch.sv
rtl/qsfp_port_ctrl.sv
rtl/apb_regs.sv
rtl/board_mgmt.sv
testbench/board_mgmt_sva.sv
testbench/tb_board_mgmt.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_mgmt
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
